//--- video_gen.f
+incdir+.
video_pkg.sv
video_regs.sv
video_timing.sv
display_fetch.sv
pixel_serializer.sv
video_gen.sv
video_gen_checker.sv
tb_video_gen.sv

//--- tb_video_gen.sv
// ====================
// video generator testbench
// sync timing, registers, text and bitmap
// frames, enable latch and frame interrupt
// ====================
`timescale 1ns/10ps
`include "video_gen_defines.svh"

module tb_video_gen;

    localparam int FRAME_CLKS = `VG_H_TOTAL * `VG_V_TOTAL;
    localparam int PIXELS     = `VG_H_VISIBLE * `VG_V_VISIBLE;

    // number, write data, expected readback
    localparam logic [35:0] REG_TABLE [7] = '{
        {4'(video_pkg::reg_dispstart), 16'h1234, 16'h1234},
        {4'(video_pkg::reg_dispwidth), 16'h0009, 16'h0009},
        {4'(video_pkg::reg_fontctrl),  16'hfff7, 16'h0007},
        {4'(video_pkg::reg_gfxctrl),   16'ha5ff, 16'ha540},
        {4'(video_pkg::reg_r_width),   16'hffff, 16'h0040},
        {4'(video_pkg::reg_r_height),  16'hffff, 16'h0010},
        {4'd7,                         16'hbeef, 16'h0000}     // unused number
    };

    // start, width, fontctrl, gfxctrl
    localparam logic [63:0] MODE_TABLE [4] = '{
        {16'h0100, 16'd8,  16'h000f, 16'h3a00},                 // text 8x16
        {16'h2000, 16'd12, 16'h0007, 16'hc000},                 // text 8x8
        {16'h4000, 16'd20, 16'h0000, 16'h5040},                 // bitmap
        {16'hfff0, 16'd16, 16'h0000, 16'h9040}                  // bitmap, address wraps
    };

    logic                    clk = 1'b0;
    logic                    reset_i;
    logic                    enable_i;
    logic                    vgen_reg_wr_i;
    logic [3:0]              vgen_reg_num_i;
    logic [15:0]             vgen_reg_data_i;
    logic [15:0]             vram_data_i;
    logic [15:0]             fontram_data_i;
    logic                    fontram_sel_o;
    logic [`VG_FONT_AW-1:0]  fontram_addr_o;
    logic                    vram_sel_o;
    logic [`VG_VRAM_AW-1:0]  vram_addr_o;
    logic [15:0]             vgen_reg_data_o;
    logic [7:0]              pal_index_o;
    logic                    bus_intr_o;
    logic                    vsync_o;
    logic                    hsync_o;
    logic                    dv_de_o;
    logic [15:0]             vram_mem [0:(1 << `VG_VRAM_AW) - 1];
    logic [15:0]             font_mem [0:(1 << `VG_FONT_AW) - 1];
    int                      error_count = 0;

    always #50 clk = ~clk;                  // 100 ns pixel clock

    // synchronous memories, data one cycle after the select
    always @(posedge clk) begin
        if (vram_sel_o) begin
            vram_data_i <= vram_mem[vram_addr_o];
        end
        if (fontram_sel_o) begin
            fontram_data_i <= font_mem[fontram_addr_o];
        end
    end

    video_gen u_video_gen (
        .fontram_sel_o   (fontram_sel_o),
        .fontram_addr_o  (fontram_addr_o),
        .vram_sel_o      (vram_sel_o),
        .vram_addr_o     (vram_addr_o),
        .vgen_reg_data_o (vgen_reg_data_o),
        .vram_data_i     (vram_data_i),
        .fontram_data_i  (fontram_data_i),
        .enable_i        (enable_i),
        .vgen_reg_wr_i   (vgen_reg_wr_i),
        .vgen_reg_num_i  (vgen_reg_num_i),
        .vgen_reg_data_i (vgen_reg_data_i),
        .pal_index_o     (pal_index_o),
        .bus_intr_o      (bus_intr_o),
        .vsync_o         (vsync_o),
        .hsync_o         (hsync_o),
        .dv_de_o         (dv_de_o),
        .reset_i         (reset_i),
        .clk             (clk)
    );

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped after the first error");
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic probe(input int sel);
        case (sel)
            0:       return hsync_o;
            1:       return vsync_o;
            default: return bus_intr_o;
        endcase
    endfunction

    task automatic wait_level(input int sel, input logic level, input int limit,
                              input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                $display("timeout while waiting for %s", what);
                abort_run();
            end
        end while (probe(sel) !== level);
    endtask

    // clocks until the signal leaves the given level
    task automatic run_length(input int sel, input logic level, input int limit, output int n);
        n = 0;
        while (probe(sel) === level) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                $display("timeout: sync or interrupt level never changed");
                abort_run();
            end
        end
    endtask

    task automatic write_reg(input logic [3:0] num, input logic [15:0] data);
        @(posedge clk);
        vgen_reg_wr_i   <= 1'b1;
        vgen_reg_num_i  <= num;
        vgen_reg_data_i <= data;
        @(posedge clk);
        vgen_reg_wr_i   <= 1'b0;
    endtask

    function automatic logic [7:0] expected_pixel(input int x, input int y,
                                                  input logic [63:0] cfg);
        logic [15:0] addr;
        logic [15:0] word;
        logic [15:0] font_word;
        logic [7:0]  glyph_row;
        logic [3:0]  nib;
        int          cell_h;
        int          row;
        cell_h = cfg[19] ? 16 : 8;          // fontctrl bit 3
        if (cfg[6]) begin
            addr = 16'(cfg[63:48] + y * cfg[47:32] + x / 4);
            word = vram_mem[addr];
            nib  = word[(15 - 4 * (x % 4)) -: 4];   // leftmost pixel on top
        end else begin
            addr      = 16'(cfg[63:48] + (y / cell_h) * cfg[47:32] + x / 8);
            word      = vram_mem[addr];
            row       = y % cell_h;
            font_word = font_mem[word[7:0] * (cell_h / 2) + row / 2];
            glyph_row = row[0] ? font_word[7:0] : font_word[15:8];
            nib       = glyph_row[7 - x % 8] ? word[11:8] : word[15:12];
        end
        return {cfg[15:12], nib};
    endfunction

    // checks every shown pixel up to the next frame interrupt
    task automatic check_frame(input logic [63:0] cfg, input bit shown);
        int n;
        int cycles;
        bit done;
        n      = 0;
        cycles = 0;
        done   = 1'b0;
        @(posedge clk);
        vgen_reg_num_i <= video_pkg::reg_r_scanline;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2 * FRAME_CLKS) begin
                $display("timeout: no frame interrupt while checking a frame");
                abort_run();
            end
            if (dv_de_o) begin
                compare("pal_index_o", pal_index_o,
                        expected_pixel(n % `VG_H_VISIBLE, n / `VG_H_VISIBLE, cfg));
                compare("vgen_reg_data_o", {vgen_reg_data_o[15:14], vgen_reg_data_o[10:0]},
                        n / `VG_H_VISIBLE);
                n++;
            end
            done = bus_intr_o;
        end
        compare("dv_de_o", n, shown ? PIXELS : 0);
        @(negedge clk);
        compare("vgen_reg_data_o[15]", vgen_reg_data_o[15], 1);    // vertical blank
    endtask

    initial begin
        int n;
        reset_i         = 1'b1;
        enable_i        = 1'b1;
        vgen_reg_wr_i   = 1'b0;
        vgen_reg_num_i  = 4'h0;
        vgen_reg_data_i = 16'h0000;
        vram_data_i     = 16'h0000;
        fontram_data_i  = 16'h0000;
        void'($urandom(5176));
        for (int i = 0; i < (1 << `VG_VRAM_AW); i++) begin
            vram_mem[i] = 16'($urandom);
        end
        for (int i = 0; i < (1 << `VG_FONT_AW); i++) begin
            font_mem[i] = 16'($urandom);
        end
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;

        wait_level(0, `VG_H_SYNC_POL, 2 * `VG_H_TOTAL, "hsync_o to go active");
        run_length(0, `VG_H_SYNC_POL, `VG_H_TOTAL, n);
        compare("hsync_o", n, `VG_H_SYNC);
        run_length(0, ~`VG_H_SYNC_POL, `VG_H_TOTAL, n);
        compare("hsync_o", n, `VG_H_TOTAL - `VG_H_SYNC);
        wait_level(1, `VG_V_SYNC_POL, 2 * FRAME_CLKS, "vsync_o to go active");
        run_length(1, `VG_V_SYNC_POL, FRAME_CLKS, n);
        compare("vsync_o", n, `VG_V_SYNC * `VG_H_TOTAL);

        foreach (REG_TABLE[i]) begin
            write_reg(REG_TABLE[i][35:32], REG_TABLE[i][31:16]);
            @(posedge clk);
            @(negedge clk);
            compare("vgen_reg_data_o", vgen_reg_data_o, REG_TABLE[i][15:0]);
        end

        // new settings go in during vertical blank
        wait_level(2, 1'b1, 2 * FRAME_CLKS, "the frame interrupt");
        foreach (MODE_TABLE[i]) begin
            write_reg(video_pkg::reg_dispstart, MODE_TABLE[i][63:48]);
            write_reg(video_pkg::reg_dispwidth, MODE_TABLE[i][47:32]);
            write_reg(video_pkg::reg_fontctrl, MODE_TABLE[i][31:16]);
            write_reg(video_pkg::reg_gfxctrl, MODE_TABLE[i][15:0]);
            check_frame(MODE_TABLE[i], 1'b1);
        end

        wait_level(2, 1'b1, 2 * FRAME_CLKS, "the frame interrupt");
        run_length(2, 1'b1, FRAME_CLKS, n);
        compare("bus_intr_o", n, 1);
        run_length(2, 1'b0, 2 * FRAME_CLKS, n);
        compare("bus_intr_o", n, FRAME_CLKS - 1);
        @(posedge clk);
        enable_i <= 1'b0;                   // sampled at this frame's end
        check_frame(MODE_TABLE[3], 1'b0);
        @(posedge clk);
        enable_i <= 1'b1;
        check_frame(MODE_TABLE[3], 1'b1);

        if (error_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

//--- video_gen_checker.sv
// ====================
// video generator port checker
// select exclusion, display enable vs sync,
// one clock frame interrupt
// ====================
`timescale 1ns/10ps
`include "video_gen_defines.svh"

module video_gen_checker (
    input  wire logic  clk,
    input  wire logic  reset_i,
    input  wire logic  vram_sel_i,
    input  wire logic  fontram_sel_i,
    input  wire logic  dv_de_i,
    input  wire logic  hsync_i,
    input  wire logic  vsync_i,
    input  wire logic  bus_intr_i
);

    a_sel_exclusive: assert property (@(posedge clk) disable iff (reset_i)
        !(vram_sel_i && fontram_sel_i))
        else $error("VRAM and font RAM selected in the same cycle");

    // no pixel may be shown while either sync is active
    a_de_outside_sync: assert property (@(posedge clk) disable iff (reset_i)
        dv_de_i |-> (hsync_i != `VG_H_SYNC_POL) && (vsync_i != `VG_V_SYNC_POL))
        else $error("dv_de_o high during a sync pulse");

    a_intr_one_clock: assert property (@(posedge clk) disable iff (reset_i)
        bus_intr_i |=> !bus_intr_i)
        else $error("bus_intr_o held for more than one clock");

endmodule

bind video_gen video_gen_checker u_video_gen_checker (
    .clk           (clk),
    .reset_i       (reset_i),
    .vram_sel_i    (vram_sel_o),
    .fontram_sel_i (fontram_sel_o),
    .dv_de_i       (dv_de_o),
    .hsync_i       (hsync_o),
    .vsync_i       (vsync_o),
    .bus_intr_i    (bus_intr_o)
);

//--- video_gen.sv
// ====================
// video generator top level
// registers, raster timing, display fetch
// and pixel serializer
// ====================
`timescale 1ns/10ps
`include "video_gen_defines.svh"

module video_gen (
    output      logic                    fontram_sel_o,
    output      logic [`VG_FONT_AW-1:0]  fontram_addr_o,
    output      logic                    vram_sel_o,
    output      logic [`VG_VRAM_AW-1:0]  vram_addr_o,
    output      logic [15:0]             vgen_reg_data_o,
    input  wire logic [15:0]             vram_data_i,
    input  wire logic [15:0]             fontram_data_i,
    input  wire logic                    enable_i,      // 0 blanks the next frame
    input  wire logic                    vgen_reg_wr_i,
    input  wire logic [`VG_REG_NUM_W-1:0] vgen_reg_num_i,
    input  wire logic [15:0]             vgen_reg_data_i,
    output      logic [7:0]              pal_index_o,
    output      logic                    bus_intr_o,
    output      logic                    vsync_o,
    output      logic                    hsync_o,
    output      logic                    dv_de_o,
    input  wire logic                    reset_i,
    input  wire logic                    clk            // pixel clock
);

    logic [15:0]              start_addr;
    logic [15:0]              line_width;
    logic [3:0]               font_height;
    logic [7:0]               colorbase;
    logic                     bitmap;
    logic                     h_visible;
    logic                     v_visible;
    logic [`VG_COUNT_W-1:0]   v_count;
    logic                     fetch_active;
    logic                     line_fetch_start;
    logic                     scanout_start;
    logic                     line_end;
    logic                     frame_end;
    logic                     next_full;
    logic                     group_valid;
    video_pkg::display_word_u group_word0;
    logic [15:0]              group_word1;

    video_regs u_video_regs (
        .clk             (clk),
        .reset_i         (reset_i),
        .vgen_reg_wr_i   (vgen_reg_wr_i),
        .vgen_reg_num_i  (video_pkg::reg_num_e'(vgen_reg_num_i)),
        .vgen_reg_data_i (vgen_reg_data_i),
        .h_visible_i     (h_visible),
        .v_visible_i     (v_visible),
        .v_count_i       (v_count),
        .vgen_reg_data_o (vgen_reg_data_o),
        .start_addr_o    (start_addr),
        .line_width_o    (line_width),
        .font_height_o   (font_height),
        .colorbase_o     (colorbase),
        .bitmap_o        (bitmap)
    );

    video_timing u_video_timing (
        .clk                (clk),
        .reset_i            (reset_i),
        .enable_i           (enable_i),
        .h_visible_o        (h_visible),
        .v_visible_o        (v_visible),
        .v_count_o          (v_count),
        .hsync_o            (hsync_o),
        .vsync_o            (vsync_o),
        .dv_de_o            (dv_de_o),
        .bus_intr_o         (bus_intr_o),
        .fetch_active_o     (fetch_active),
        .line_fetch_start_o (line_fetch_start),
        .scanout_start_o    (scanout_start),
        .line_end_o         (line_end),
        .frame_end_o        (frame_end)
    );

    display_fetch u_display_fetch (
        .clk                (clk),
        .reset_i            (reset_i),
        .fetch_active_i     (fetch_active),
        .line_fetch_start_i (line_fetch_start),
        .line_end_i         (line_end),
        .frame_end_i        (frame_end),
        .start_addr_i       (start_addr),
        .line_width_i       (line_width),
        .font_height_i      (font_height),
        .colorbase_i        (colorbase),
        .bitmap_i           (bitmap),
        .vram_data_i        (vram_data_i),
        .fontram_data_i     (fontram_data_i),
        .next_full_i        (next_full),
        .vram_sel_o         (vram_sel_o),
        .vram_addr_o        (vram_addr_o),
        .fontram_sel_o      (fontram_sel_o),
        .fontram_addr_o     (fontram_addr_o),
        .group_valid_o      (group_valid),
        .group_word0_o      (group_word0),
        .group_word1_o      (group_word1)
    );

    pixel_serializer u_pixel_serializer (
        .clk              (clk),
        .reset_i          (reset_i),
        .group_valid_i    (group_valid),
        .group_word0_i    (group_word0),
        .group_word1_i    (group_word1),
        .colorbase_i      (colorbase),
        .bitmap_i         (bitmap),
        .scanout_start_i  (scanout_start),
        .scanout_active_i (h_visible),
        .next_full_o      (next_full),
        .pal_index_o      (pal_index_o)
    );

endmodule

//--- pixel_serializer.sv
// ====================
// pixel serializer
// expands fetched words to 8 palette indices
// and shifts them out one per clock
// ====================
`timescale 1ns/10ps

module pixel_serializer (
    input  wire logic                      clk,
    input  wire logic                      reset_i,
    input  wire logic                      group_valid_i,
    input  wire video_pkg::display_word_u  group_word0_i,
    input  wire logic [15:0]               group_word1_i,
    input  wire logic [7:0]                colorbase_i,
    input  wire logic                      bitmap_i,
    input  wire logic                      scanout_start_i,
    input  wire logic                      scanout_active_i,
    output      logic                      next_full_o,
    output      logic [7:0]                pal_index_o
);

    logic [7:0][7:0] expanded;              // [7] is the leftmost pixel
    logic [7:0][7:0] next_buf;
    logic [7:0][7:0] shifter;
    logic [2:0]      tile_x;
    logic            load;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            if (bitmap_i) begin
                expanded[i][3:0] = (i >= 4) ? group_word0_i.pix[i-4] : group_word1_i[4*i +: 4];
            end else begin
                expanded[i][3:0] = group_word1_i[i] ? group_word0_i.tile.fg
                                                    : group_word0_i.tile.bg;
            end
            expanded[i][7:4] = colorbase_i[7:4];
        end
    end

    assign load = scanout_start_i || (scanout_active_i && tile_x == 3'd7);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            next_full_o <= 1'b0;
            tile_x      <= 3'd0;
            pal_index_o <= 8'h00;
        end else begin
            if (scanout_start_i) begin
                tile_x <= 3'd0;
            end else if (scanout_active_i) begin
                tile_x <= tile_x + 1'b1;
            end
            if (group_valid_i) begin
                next_full_o <= 1'b1;
            end else if (load) begin
                next_full_o <= 1'b0;            // buffer moved to shifter
            end
            pal_index_o <= scanout_active_i ? shifter[7] : 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (group_valid_i) begin
            next_buf <= expanded;
        end
        if (load) begin
            shifter <= next_buf;
        end else if (scanout_active_i) begin
            shifter <= {shifter[6:0], 8'h00};
        end
    end

endmodule

//--- display_fetch.sv
// ====================
// display memory fetch
// VRAM/font RAM address generation and
// 8 cycle per group fetch sequencer
// ====================
`timescale 1ns/10ps
`include "video_gen_defines.svh"

module display_fetch (
    input  wire logic                      clk,
    input  wire logic                      reset_i,
    input  wire logic                      fetch_active_i,
    input  wire logic                      line_fetch_start_i,
    input  wire logic                      line_end_i,
    input  wire logic                      frame_end_i,
    input  wire logic [15:0]               start_addr_i,
    input  wire logic [15:0]               line_width_i,
    input  wire logic [3:0]                font_height_i,
    input  wire logic [7:0]                colorbase_i,
    input  wire logic                      bitmap_i,
    input  wire logic [15:0]               vram_data_i,
    input  wire logic [15:0]               fontram_data_i,
    input  wire logic                      next_full_i,
    output      logic                      vram_sel_o,
    output      logic [`VG_VRAM_AW-1:0]    vram_addr_o,
    output      logic                      fontram_sel_o,
    output      logic [`VG_FONT_AW-1:0]    fontram_addr_o,
    output      logic                      group_valid_o,
    output      video_pkg::display_word_u  group_word0_o,
    output      logic [15:0]               group_word1_o
);

    logic [2:0]               fetch_cycle;
    logic                     first_group;       // primes the next buffer only
    logic                     step;
    logic [`VG_VRAM_AW-1:0]   disp_addr;
    logic [`VG_VRAM_AW-1:0]   line_addr;          // first word of the current cell row
    logic [3:0]               tile_y;
    video_pkg::display_word_u hot_word;           // memory output, not yet captured
    logic [`VG_FONT_AW-1:0]   font_addr;

    assign hot_word = vram_data_i;

    // two glyph rows per font word, so tile_y[0] picks the byte later
    assign font_addr = font_height_i[3] ? {hot_word.tile.glyph, tile_y[3:1]}
                                        : {1'b0, hot_word.tile.glyph, tile_y[2:1]};

    // hold in cycle 1 until the serializer has taken the last group
    assign step = fetch_active_i && !(next_full_i && fetch_cycle == 3'd1);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_cycle   <= 3'd0;
            first_group   <= 1'b0;
            vram_sel_o    <= 1'b0;
            fontram_sel_o <= 1'b0;
            group_valid_o <= 1'b0;
            disp_addr     <= '0;
            line_addr     <= '0;
            tile_y        <= 4'h0;
        end else begin
            vram_sel_o    <= 1'b0;
            fontram_sel_o <= 1'b0;
            group_valid_o <= 1'b0;
            if (step) begin
                fetch_cycle <= fetch_cycle + 1'b1;
                case (fetch_cycle)
                    3'd0: begin
                        vram_sel_o <= 1'b1;                     // display word
                        disp_addr  <= disp_addr + 1'b1;
                    end
                    3'd1: group_valid_o <= !first_group;
                    3'd2: begin
                        if (bitmap_i) begin
                            vram_sel_o <= 1'b1;                 // second pixel word
                            disp_addr  <= disp_addr + 1'b1;
                        end else begin
                            fontram_sel_o <= 1'b1;              // glyph rows
                        end
                    end
                    3'd7: first_group <= 1'b0;
                    default: ;
                endcase
            end

            if (line_fetch_start_i) begin
                fetch_cycle <= 3'd0;
                first_group <= 1'b1;
            end

            if (line_end_i) begin
                if (bitmap_i || tile_y == font_height_i) begin
                    tile_y    <= 4'h0;
                    line_addr <= line_addr + line_width_i;
                    disp_addr <= line_addr + line_width_i;
                end else begin
                    tile_y    <= tile_y + 1'b1;
                    disp_addr <= line_addr;             // same cells again
                end
            end

            if (frame_end_i) begin
                disp_addr <= start_addr_i;
                line_addr <= start_addr_i;
                tile_y    <= 4'h0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            case (fetch_cycle)
                3'd0: vram_addr_o <= disp_addr;
                3'd2: begin
                    group_word0_o <= vram_data_i;
                    if (bitmap_i) begin
                        vram_addr_o <= disp_addr;
                    end else begin
                        fontram_addr_o <= font_addr;
                    end
                end
                3'd4: group_word1_o <= bitmap_i ? vram_data_i : fontram_data_i;
                3'd5: begin
                    if (!bitmap_i && !tile_y[0]) begin
                        group_word1_o[7:0] <= group_word1_o[15:8];  // even row in high byte
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- video_timing.sv
// ====================
// video raster timing
// sync state machines, fetch window,
// line/frame events and frame interrupt
// ====================
`timescale 1ns/10ps
`include "video_gen_defines.svh"

module video_timing (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    enable_i,
    output      logic                    h_visible_o,
    output      logic                    v_visible_o,
    output      logic [`VG_COUNT_W-1:0]  v_count_o,
    output      logic                    hsync_o,
    output      logic                    vsync_o,
    output      logic                    dv_de_o,
    output      logic                    bus_intr_o,
    output      logic                    fetch_active_o,
    output      logic                    line_fetch_start_o,
    output      logic                    scanout_start_o,
    output      logic                    line_end_o,
    output      logic                    frame_end_o
);

    localparam int CW = `VG_COUNT_W;
    localparam logic [CW-1:0] H_FETCH_BEGIN = CW'(`VG_H_OFFSCREEN - `VG_FETCH_LEAD);
    localparam logic [CW-1:0] H_SCANOUT     = CW'(`VG_H_OFFSCREEN - 1);

    video_pkg::sync_state_e h_state;
    video_pkg::sync_state_e v_state;
    logic [CW-1:0]          h_count;
    logic [CW-1:0]          h_limit;            // last count of current h state
    logic [CW-1:0]          v_limit;            // last line of current v state
    logic                   last_visible;
    logic                   vg_enable;          // sampled at frame end

    always_comb begin
        case (h_state)
            video_pkg::pre_sync:  h_limit = CW'(`VG_H_FRONT - 1);
            video_pkg::sync:      h_limit = CW'(`VG_H_FRONT + `VG_H_SYNC - 1);
            video_pkg::post_sync: h_limit = CW'(`VG_H_OFFSCREEN - 1);
            default:              h_limit = CW'(`VG_H_TOTAL - 1);
        endcase
        // visible lines come first, blanking below
        case (v_state)
            video_pkg::pre_sync:  v_limit = CW'(`VG_V_VISIBLE + `VG_V_FRONT - 1);
            video_pkg::sync:      v_limit = CW'(`VG_V_VISIBLE + `VG_V_FRONT + `VG_V_SYNC - 1);
            video_pkg::post_sync: v_limit = CW'(`VG_V_TOTAL - 1);
            default:              v_limit = CW'(`VG_V_VISIBLE - 1);
        endcase
    end

    assign h_visible_o        = (h_state == video_pkg::visible);
    assign v_visible_o        = (v_state == video_pkg::visible);
    assign line_end_o         = h_visible_o && (h_count == h_limit);
    assign frame_end_o        = line_end_o && (v_state == video_pkg::post_sync) && (v_count_o == v_limit);
    assign last_visible       = line_end_o && v_visible_o && (v_count_o == v_limit);
    assign fetch_active_o     = v_visible_o && (h_count >= H_FETCH_BEGIN);
    assign line_fetch_start_o = v_visible_o && (h_count == H_FETCH_BEGIN - 1'b1);
    assign scanout_start_o    = v_visible_o && (h_count == H_SCANOUT);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state    <= video_pkg::pre_sync;
            v_state    <= video_pkg::pre_sync;
            h_count    <= '0;
            v_count_o  <= '0;
            vg_enable  <= 1'b1;
            hsync_o    <= ~`VG_H_SYNC_POL;
            vsync_o    <= ~`VG_V_SYNC_POL;
            dv_de_o    <= 1'b0;
            bus_intr_o <= 1'b0;
        end else begin
            h_count <= line_end_o ? '0 : h_count + 1'b1;
            if (h_count == h_limit) begin
                h_state <= video_pkg::sync_state_e'(h_state + 2'd1);
            end
            if (line_end_o) begin
                v_count_o <= frame_end_o ? '0 : v_count_o + 1'b1;
                if (v_count_o == v_limit) begin
                    v_state <= video_pkg::sync_state_e'(v_state + 2'd1);
                end
            end
            if (frame_end_o) begin
                vg_enable <= enable_i;          // holds for the whole next frame
            end

            hsync_o    <= (h_state == video_pkg::sync) ? `VG_H_SYNC_POL : ~`VG_H_SYNC_POL;
            vsync_o    <= (v_state == video_pkg::sync) ? `VG_V_SYNC_POL : ~`VG_V_SYNC_POL;
            dv_de_o    <= vg_enable && h_visible_o && v_visible_o;
            bus_intr_o <= last_visible;         // one clock after last visible pixel
        end
    end

endmodule

//--- video_regs.sv
// ====================
// video register file
// config writes and registered readback
// ====================
`timescale 1ns/10ps
`include "video_gen_defines.svh"

module video_regs (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    vgen_reg_wr_i,
    input  wire video_pkg::reg_num_e     vgen_reg_num_i,
    input  wire logic [15:0]             vgen_reg_data_i,
    input  wire logic                    h_visible_i,
    input  wire logic                    v_visible_i,
    input  wire logic [`VG_COUNT_W-1:0]  v_count_i,
    output      logic [15:0]             vgen_reg_data_o,
    output      logic [15:0]             start_addr_o,
    output      logic [15:0]             line_width_o,
    output      logic [3:0]              font_height_o,
    output      logic [7:0]              colorbase_o,
    output      logic                    bitmap_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            start_addr_o    <= 16'h0000;
            line_width_o    <= 16'(`VG_H_VISIBLE / 8);  // one text row of cells
            font_height_o   <= 4'hf;                     // 8x16 cells
            colorbase_o     <= 8'h00;
            bitmap_o        <= 1'b0;                     // text mode
            vgen_reg_data_o <= 16'h0000;
        end else begin
            if (vgen_reg_wr_i) begin
                case (vgen_reg_num_i)
                    video_pkg::reg_dispstart: start_addr_o <= vgen_reg_data_i;
                    video_pkg::reg_dispwidth: line_width_o <= vgen_reg_data_i;
                    video_pkg::reg_fontctrl:  font_height_o <= vgen_reg_data_i[3:0];
                    video_pkg::reg_gfxctrl: begin
                        colorbase_o <= vgen_reg_data_i[15:8];
                        bitmap_o    <= vgen_reg_data_i[6];
                    end
                    default: ;                           // read only or unused
                endcase
            end

            case (vgen_reg_num_i)
                video_pkg::reg_dispstart:  vgen_reg_data_o <= start_addr_o;
                video_pkg::reg_dispwidth:  vgen_reg_data_o <= line_width_o;
                video_pkg::reg_fontctrl:   vgen_reg_data_o <= {12'h000, font_height_o};
                video_pkg::reg_gfxctrl:    vgen_reg_data_o <= {colorbase_o, 1'b0, bitmap_o, 6'h00};
                video_pkg::reg_r_width:    vgen_reg_data_o <= 16'(`VG_H_VISIBLE);
                video_pkg::reg_r_height:   vgen_reg_data_o <= 16'(`VG_V_VISIBLE);
                video_pkg::reg_r_scanline: begin
                    // top bit set means outside the visible frame
                    vgen_reg_data_o <= {~v_visible_i, ~h_visible_i, 3'b000, v_count_i};
                end
                default:                   vgen_reg_data_o <= 16'h0000;
            endcase
        end
    end

endmodule

//--- video_pkg.sv
// ====================
// video generator shared types
// sync states, register numbers, display word
// ====================
`include "video_gen_defines.svh"

package video_pkg;

    typedef enum logic [1:0] {
        pre_sync  = 2'b00,              // front porch
        sync      = 2'b01,
        post_sync = 2'b10,              // back porch
        visible   = 2'b11
    } sync_state_e;

    typedef enum logic [`VG_REG_NUM_W-1:0] {
        reg_dispstart  = 4'd0,
        reg_dispwidth  = 4'd1,
        reg_fontctrl   = 4'd2,
        reg_gfxctrl    = 4'd3,
        reg_r_width    = 4'd4,          // read only
        reg_r_height   = 4'd5,          // read only
        reg_r_scanline = 4'd6           // read only, live
    } reg_num_e;

    typedef struct packed {
        logic [3:0] bg;                 // background colour
        logic [3:0] fg;                 // foreground colour
        logic [7:0] glyph;              // font glyph index
    } tile_word_t;

    // one VRAM word, seen as a text cell or as four 4 bpp pixels
    typedef union packed {
        tile_word_t      tile;
        logic [3:0][3:0] pix;           // pix[3] is leftmost
    } display_word_u;

endpackage

//--- video_gen_defines.svh
// ====================
// video generator raster timing, sync polarity
// and bus width definitions
// ====================
`ifndef VIDEO_GEN_DEFINES_SVH
`define VIDEO_GEN_DEFINES_SVH

// horizontal raster, in pixel clocks
`define VG_H_VISIBLE    64
`define VG_H_FRONT      4
`define VG_H_SYNC       8
`define VG_H_BACK       12
`define VG_H_OFFSCREEN  (`VG_H_FRONT + `VG_H_SYNC + `VG_H_BACK)
`define VG_H_TOTAL      (`VG_H_OFFSCREEN + `VG_H_VISIBLE)

// vertical raster, in lines
`define VG_V_VISIBLE    16
`define VG_V_FRONT      1
`define VG_V_SYNC       2
`define VG_V_BACK       2
`define VG_V_TOTAL      (`VG_V_VISIBLE + `VG_V_FRONT + `VG_V_SYNC + `VG_V_BACK)

// active sync levels
`define VG_H_SYNC_POL   1'b0
`define VG_V_SYNC_POL   1'b0

// line fetch begins this many clocks ahead of the visible area
`define VG_FETCH_LEAD   16

`define VG_COUNT_W      11
`define VG_VRAM_AW      16
`define VG_FONT_AW      11
`define VG_REG_NUM_W    4

`endif
